//--- Bender.yml
package:
  name: vertex_stage

sources:
  - logic/vs_pkg.sv
  - logic/dot_if.sv
  - logic/dot4_unit.sv
  - logic/dot_arbiter.sv
  - logic/fixed_divider.sv
  - logic/vertex_xform.sv
  - logic/face_shade.sv
  - logic/frame_latch.sv
  - logic/vs_top.sv
  - target: test
    files:
      - tests/vs_assertions.sv
      - tests/vs_checker.sv
      - tests/vs_tb.sv

//--- logic/dot4_unit.sv
// four-term Q8.8 dot product on a single multiplier, one term per cycle, served via dot_if
module dot4_unit import vs_pkg::*; #(
	parameter int FRAC_BITS = 8
) (
	input logic clk,
	input logic reset,
	dot_if.server i_dot
);
	logic busy;
	logic [2:0] term;				// 0..3 accumulate, 4 truncates
	logic signed [31:0] acc;
	logic signed [31:0] prod;
	logic signed [31:0] scaled;
	fix16_t op_a;
	fix16_t op_b;

	// operand select by term
	always_comb begin
		case (term[1:0])
			2'd0: begin
				op_a = i_dot.v1.x;
				op_b = i_dot.v2.x;
			end
			2'd1: begin
				op_a = i_dot.v1.y;
				op_b = i_dot.v2.y;
			end
			2'd2: begin
				op_a = i_dot.v1.z;
				op_b = i_dot.v2.z;
			end
			default: begin
				op_a = i_dot.v1.w;
				op_b = i_dot.v2.w;
			end
		endcase
	end

	assign prod = op_a * op_b;				// Q16.16
	assign scaled = acc >>> FRAC_BITS;		// back to Q8.8, sign kept

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			term <= '0;
			i_dot.done <= 1'b0;
		end else begin
			i_dot.done <= 1'b0;
			if (!busy) begin
				term <= '0;
				busy <= i_dot.start && !i_dot.done;	// start is still up in the done cycle
			end else if (!term[2]) begin
				term <= term + 3'd1;
			end else begin
				busy <= 1'b0;
				i_dot.done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy)
			acc <= '0;
		else if (!term[2])
			acc <= acc + prod;
		if (busy && term[2])
			i_dot.result <= scaled[15:0];	// plain truncation, no saturation
	end

endmodule

//--- logic/dot_arbiter.sv
// shares the dot unit between the transform and shade requesters, transform first
module dot_arbiter (
	input logic clk,
	input logic reset,
	dot_if.arbiter i_xform,
	dot_if.arbiter i_shade,
	dot_if.requester o_unit
);
	logic locked;			// owner holds the unit until its done
	logic owner_shade;
	logic gnt_xform;
	logic gnt_shade;

	// grant is immediate while the unit is free
	assign gnt_xform = locked ? !owner_shade : i_xform.start;
	assign gnt_shade = locked ? owner_shade : (!i_xform.start && i_shade.start);

	assign o_unit.start = (gnt_xform && i_xform.start) || (gnt_shade && i_shade.start);
	assign o_unit.v1 = gnt_shade ? i_shade.v1 : i_xform.v1;
	assign o_unit.v2 = gnt_shade ? i_shade.v2 : i_xform.v2;

	// results go back to the owner only
	assign i_xform.done = o_unit.done && gnt_xform;
	assign i_shade.done = o_unit.done && gnt_shade;
	assign i_xform.result = gnt_xform ? o_unit.result : '0;
	assign i_shade.result = gnt_shade ? o_unit.result : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			owner_shade <= 1'b0;
		end else if (!locked) begin
			locked <= i_xform.start || i_shade.start;
			owner_shade <= gnt_shade;
		end else if (o_unit.done) begin
			locked <= 1'b0;					// free again for the next request
		end
	end

endmodule

//--- logic/dot_if.sv
// one dot-product request and its result, shared by requesters, the arbiter and the dot unit
interface dot_if import vs_pkg::*; ();

	logic start;		// level, held with stable operands until done
	vec4_t v1;
	vec4_t v2;
	logic done;			// single cycle pulse
	fix16_t result;		// valid in the done cycle only

	// request side
	modport requester (output start, v1, v2, input done, result);

	// arbiter faces the requesters with the same view as the unit
	modport arbiter (input start, v1, v2, output done, result);

	modport server (input start, v1, v2, output done, result);

endinterface

//--- logic/face_shade.sv
// flat shade of the quad: one dot(normal, light) request, quantized to a 3-bit level
module face_shade import vs_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_start,
	input vec4_t i_normal,					// w taken as 0
	input vec4_t i_light,
	dot_if.requester o_dot,
	output logic o_shade_done,
	output shade_t o_color
);
	logic [15:0] mag;
	logic [15:0] level;

	assign o_dot.v1 = {i_normal.x, i_normal.y, i_normal.z, 16'sd0};
	assign o_dot.v2 = {i_light.x, i_light.y, i_light.z, 16'sd0};

	// back faces are lit by the reversed normal
	assign mag = o_dot.result[15] ? 16'(-o_dot.result) : o_dot.result;
	assign level = mag >> SHADE_SHIFT;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_dot.start <= 1'b0;
			o_shade_done <= 1'b0;
		end else begin
			o_shade_done <= 1'b0;
			if (o_dot.done) begin
				o_dot.start <= 1'b0;
				o_shade_done <= 1'b1;
			end else if (i_start && !o_dot.start) begin
				o_dot.start <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (o_dot.done)
			o_color <= (level > SHADE_MAX) ? shade_t'(SHADE_MAX) : level[2:0];
	end

endmodule

//--- logic/fixed_divider.sv
// serial restoring divider for the perspective divide, returns a saturated fixed-point quotient
module fixed_divider import vs_pkg::*; #(
	parameter int WIDTH = 32,
	parameter int FBITS = 14
) (
	input logic clk,
	input logic reset,
	input logic i_start,
	input fix16_t i_a,
	input fix16_t i_b,
	output logic o_done,
	output ndc_t o_q
);
	localparam int CW = $clog2(WIDTH + 1);

	logic busy;
	logic [CW-1:0] cnt;
	logic neg;
	logic [WIDTH-1:0] quo;			// dividend shifts out, quotient shifts in
	logic [WIDTH-1:0] rem;
	logic [WIDTH-1:0] den;
	logic [WIDTH:0] shifted;
	logic [WIDTH:0] trial;
	logic [15:0] a_mag;
	logic [15:0] b_mag;
	logic [WIDTH-1:0] limit;
	logic [WIDTH-1:0] mag;

	assign a_mag = i_a[15] ? 16'(-i_a) : i_a;	// -32768 maps to 32768 unsigned
	assign b_mag = i_b[15] ? 16'(-i_b) : i_b;
	assign shifted = {rem, quo[WIDTH-1]};
	assign trial = shifted - {1'b0, den};
	assign limit = neg ? WIDTH'(32768) : WIDTH'(32767);
	assign mag = (quo > limit) ? limit : quo;	// zero divisor gives all ones here

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (!busy) begin
				busy <= i_start;
				cnt <= '0;
			end else if (cnt != CW'(WIDTH)) begin
				cnt <= cnt + 1'b1;
			end else begin
				busy <= 1'b0;
				o_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			quo <= WIDTH'(a_mag) << FBITS;
			rem <= '0;
			den <= WIDTH'(b_mag);
			neg <= (i_b == '0) ? i_a[15] : (i_a[15] ^ i_b[15]);
		end else if (cnt != CW'(WIDTH)) begin
			if (!trial[WIDTH]) begin		// fits, keep the difference
				rem <= trial[WIDTH-1:0];
				quo <= {quo[WIDTH-2:0], 1'b1};
			end else begin
				rem <= shifted[WIDTH-1:0];
				quo <= {quo[WIDTH-2:0], 1'b0};
			end
		end else begin
			o_q <= neg ? ndc_t'(-mag[15:0]) : ndc_t'(mag[15:0]);
		end
	end

endmodule

//--- logic/frame_latch.sv
// pending quad and colour, copied to the raster outputs only at the start of vertical blanking
module frame_latch import vs_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [9:0] i_x,
	input logic [9:0] i_y,
	input logic i_verts_done,
	input screen_t i_x_pend [NUM_VERTS],
	input screen_t i_y_pend [NUM_VERTS],
	input logic i_shade_done,
	input shade_t i_color_pend,
	output screen_t o_x_screen [NUM_VERTS],
	output screen_t o_y_screen [NUM_VERTS],
	output shade_t o_tri_color
);
	screen_t x_hold [NUM_VERTS];
	screen_t y_hold [NUM_VERTS];
	shade_t color_hold;
	logic at_vblank;

	assign at_vblank = (i_x == 10'd0) && (i_y == 10'(VBLANK_LINE));

	always_ff @(posedge clk) begin
		if (reset) begin
			x_hold <= '{default: '0};
			y_hold <= '{default: '0};
			color_hold <= '0;
			o_x_screen <= '{default: '0};
			o_y_screen <= '{default: '0};
			o_tri_color <= '0;
		end else begin
			if (i_verts_done) begin
				x_hold <= i_x_pend;
				y_hold <= i_y_pend;
			end
			if (i_shade_done)
				color_hold <= i_color_pend;
			if (at_vblank) begin		// whole quad at once, never half updated
				o_x_screen <= x_hold;
				o_y_screen <= y_hold;
				o_tri_color <= color_hold;
			end
		end
	end

endmodule

//--- logic/vertex_xform.sv
// per-quad vertex sequencer: clip transform, divide by w and viewport map of four vertices
module vertex_xform import vs_pkg::*; #(
	parameter int WIDTH = 32,
	parameter int FBITS = 14
) (
	input logic clk,
	input logic reset,
	input logic i_start,
	input vec4_t i_world [NUM_VERTS],		// w ignored
	input vec4_t i_vp_row0,
	input vec4_t i_vp_row1,
	input vec4_t i_vp_row3,
	dot_if.requester o_dot,
	output logic o_verts_done,
	output screen_t o_x_screen [NUM_VERTS],
	output screen_t o_y_screen [NUM_VERTS],
	output logic o_busy
);
	typedef enum logic [2:0] {S_IDLE, S_DOT, S_DIV, S_MAP, S_DONE} state_t;

	state_t state;
	logic [1:0] vtx;
	logic [1:0] row;						// 0 x row, 1 y row, 2 w row
	logic axis;								// divide y/w when set
	fix16_t clip_x [NUM_VERTS];
	fix16_t clip_y [NUM_VERTS];
	fix16_t clip_w [NUM_VERTS];
	ndc_t ndc_x [NUM_VERTS];
	ndc_t ndc_y [NUM_VERTS];
	logic div_start;
	logic div_done;
	fix16_t div_a;
	ndc_t div_q;

	// ndc * half + half, the shift drops the Q2.14 fraction
	function automatic screen_t to_screen(ndc_t n, int half);
		logic signed [31:0] p;
		p = n * half;
		return screen_t'((p >>> FBITS) + half);
	endfunction

	assign o_dot.v1 = {i_world[vtx].x, i_world[vtx].y, i_world[vtx].z, FIX_ONE};
	assign o_dot.v2 = (row == 2'd0) ? i_vp_row0 : (row == 2'd1) ? i_vp_row1 : i_vp_row3;
	assign div_a = axis ? clip_y[vtx] : clip_x[vtx];
	assign o_verts_done = (state == S_DONE);
	assign o_busy = (state != S_IDLE);

	fixed_divider #(.WIDTH(WIDTH), .FBITS(FBITS)) div_inst (
		.clk(clk),
		.reset(reset),
		.i_start(div_start),
		.i_a(div_a),
		.i_b(clip_w[vtx]),
		.o_done(div_done),
		.o_q(div_q)
	);

	//////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			vtx <= '0;
			row <= '0;
			axis <= 1'b0;
			div_start <= 1'b0;
			o_dot.start <= 1'b0;
		end else begin
			div_start <= 1'b0;
			case (state)
				S_IDLE: if (i_start) begin
					state <= S_DOT;
					vtx <= '0;
					row <= '0;
				end
				S_DOT: if (o_dot.done) begin
					o_dot.start <= 1'b0;			// low for one cycle between requests
					row <= (row == 2'd2) ? 2'd0 : row + 2'd1;
					if (row == 2'd2)
						vtx <= vtx + 2'd1;			// wraps to 0 for the divides
					if (row == 2'd2 && vtx == 2'(NUM_VERTS - 1)) begin
						state <= S_DIV;
						axis <= 1'b0;
						div_start <= 1'b1;
					end
				end else if (!o_dot.start) begin
					o_dot.start <= 1'b1;
				end
				S_DIV: if (div_done) begin
					axis <= !axis;
					if (axis)
						vtx <= vtx + 2'd1;
					if (axis && vtx == 2'(NUM_VERTS - 1))
						state <= S_MAP;
					else
						div_start <= 1'b1;
				end
				S_MAP: state <= S_DONE;
				default: state <= S_IDLE;		// S_DONE strobes the frame latch
			endcase
		end
	end

	//////////////////////////////////////////////////
	// clip, ndc and screen values
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (state == S_DOT && o_dot.done) begin
			case (row)
				2'd0: clip_x[vtx] <= o_dot.result;
				2'd1: clip_y[vtx] <= o_dot.result;
				default: clip_w[vtx] <= o_dot.result;
			endcase
		end
		if (state == S_DIV && div_done) begin
			if (axis)
				ndc_y[vtx] <= div_q;
			else
				ndc_x[vtx] <= div_q;
		end
		if (state == S_MAP) begin
			for (int v = 0; v < NUM_VERTS; v++) begin
				o_x_screen[v] <= to_screen(ndc_x[v], SCREEN_HALF_W);
				o_y_screen[v] <= to_screen(ndc_y[v], SCREEN_HALF_H);
			end
		end
	end

endmodule

//--- logic/vs_pkg.sv
// shared fixed-point types and constants for the vertex stage, imported by every design unit
package vs_pkg;

	//////////////////////////////////////////////////
	// number formats
	//////////////////////////////////////////////////
	typedef logic signed [15:0] fix16_t;	// Q8.8
	typedef logic signed [15:0] ndc_t;		// Q2.14
	typedef logic signed [19:0] screen_t;	// integer pixel
	typedef logic [2:0] shade_t;			// flat shade level

	typedef struct packed {
		fix16_t x;
		fix16_t y;
		fix16_t z;
		fix16_t w;
	} vec4_t;

	//////////////////////////////////////////////////
	// screen and quad geometry
	//////////////////////////////////////////////////
	localparam int NUM_VERTS = 4;
	localparam int SCREEN_HALF_W = 320;		// 640 wide
	localparam int SCREEN_HALF_H = 240;		// 480 high
	localparam int VBLANK_LINE = 480;		// first line past the visible area

	localparam fix16_t FIX_ONE = 16'sh0100;	// homogeneous w of a point

	// shade level = |dot| >> 5, clipped at 7
	localparam int SHADE_SHIFT = 5;
	localparam int SHADE_MAX = 7;

endpackage

//--- logic/vs_top.sv
// vertex stage top level: transform and shade share one dot unit, results shown per frame
module vs_top import vs_pkg::*; #(
	parameter int DIV_WIDTH = 32,
	parameter int DIV_FBITS = 14,
	parameter int DOT_FRAC_BITS = 8
) (
	input logic clk,
	input logic reset,
	input logic [9:0] i_x,
	input logic [9:0] i_y,
	input logic i_pc_data_ready,				// single cycle pulse
	input vec4_t i_world [NUM_VERTS],			// Q8.8, w ignored
	input vec4_t i_normal,
	input vec4_t i_light,
	input vec4_t i_vp_row0,
	input vec4_t i_vp_row1,
	input vec4_t i_vp_row3,
	output screen_t o_x_screen [NUM_VERTS],
	output screen_t o_y_screen [NUM_VERTS],
	output shade_t o_tri_color,
	output logic o_busy
);
	logic quad_start;
	logic xform_busy;
	logic verts_done;
	logic shade_done;
	shade_t color_pend;
	screen_t x_pend [NUM_VERTS];
	screen_t y_pend [NUM_VERTS];

	dot_if xform_dot ();
	dot_if shade_dot ();
	dot_if unit_dot ();

	// a pulse while busy is dropped for both producers
	assign quad_start = i_pc_data_ready && !o_busy;
	assign o_busy = xform_busy || shade_dot.start || shade_done;

	vertex_xform #(.WIDTH(DIV_WIDTH), .FBITS(DIV_FBITS)) xform_inst (
		.clk(clk),
		.reset(reset),
		.i_start(quad_start),
		.i_world(i_world),
		.i_vp_row0(i_vp_row0),
		.i_vp_row1(i_vp_row1),
		.i_vp_row3(i_vp_row3),
		.o_dot(xform_dot),
		.o_verts_done(verts_done),
		.o_x_screen(x_pend),
		.o_y_screen(y_pend),
		.o_busy(xform_busy)
	);

	face_shade shade_inst (
		.clk(clk),
		.reset(reset),
		.i_start(quad_start),
		.i_normal(i_normal),
		.i_light(i_light),
		.o_dot(shade_dot),
		.o_shade_done(shade_done),
		.o_color(color_pend)
	);

	dot_arbiter arb_inst (
		.clk(clk),
		.reset(reset),
		.i_xform(xform_dot),
		.i_shade(shade_dot),
		.o_unit(unit_dot)
	);

	dot4_unit #(.FRAC_BITS(DOT_FRAC_BITS)) dot_inst (
		.clk(clk),
		.reset(reset),
		.i_dot(unit_dot)
	);

	frame_latch latch_inst (
		.clk(clk),
		.reset(reset),
		.i_x(i_x),
		.i_y(i_y),
		.i_verts_done(verts_done),
		.i_x_pend(x_pend),
		.i_y_pend(y_pend),
		.i_shade_done(shade_done),
		.i_color_pend(color_pend),
		.o_x_screen(o_x_screen),
		.o_y_screen(o_y_screen),
		.o_tri_color(o_tri_color)
	);

endmodule

//--- tests/vs_assertions.sv
// concurrent checks on the dot arbiter and the frame outputs, bound into the vertex stage top
module vs_assertions import vs_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_xform_done,
	input logic i_shade_done,
	input logic i_unit_start,
	input logic i_unit_done,
	input logic [9:0] i_x,
	input logic [9:0] i_y,
	input shade_t i_tri_color
);
	int fails = 0;					// read back by the testbench
	logic at_vblank;

	assign at_vblank = (i_x == 10'd0) && (i_y == 10'(VBLANK_LINE));

	// each unit result reaches exactly one requester
	a_one_grant: assert property (@(posedge clk) disable iff (reset)
		i_unit_done |-> (i_xform_done ^ i_shade_done))
		else begin
			$error("dot result routed to both requesters or to none");
			fails++;
		end

	// start is still high in the done cycle
	a_done_after_start: assert property (@(posedge clk) disable iff (reset)
		i_unit_done |-> i_unit_start && $past(i_unit_start))
		else begin
			$error("dot unit done without a held start");
			fails++;
		end

	a_color_at_vblank: assert property (@(posedge clk) disable iff (reset)
		$changed(i_tri_color) |-> $past(at_vblank))
		else begin
			$error("tri colour changed away from the blanking position");
			fails++;
		end

endmodule

//--- tests/vs_checker.sv
// compares the vertex stage raster outputs with expected values on each check request
module vs_checker import vs_pkg::*; (
	input logic clk,
	input logic i_check,						// one cycle, sampled at negedge
	input screen_t [NUM_VERTS-1:0] i_exp_x,
	input screen_t [NUM_VERTS-1:0] i_exp_y,
	input shade_t i_exp_color,
	input screen_t i_x_screen [NUM_VERTS],
	input screen_t i_y_screen [NUM_VERTS],
	input shade_t i_tri_color,
	input logic i_busy,
	output int o_errors,
	output int o_checks
);
	int errors = 0;
	int checks = 0;

	assign o_errors = errors;
	assign o_checks = checks;

	// outputs settle between edges
	always @(negedge clk) begin
		if (i_check) begin
			checks++;
			if (i_busy !== 1'b0) begin
				errors++;
				$display("Error at %0t: o_busy is %b, expected 0", $time, i_busy);
			end
			for (int v = 0; v < NUM_VERTS; v++) begin
				if (i_x_screen[v] !== i_exp_x[v]) begin
					errors++;
					$display("Error at %0t: vertex %0d x is %0d, expected %0d",
						$time, v, $signed(i_x_screen[v]), $signed(i_exp_x[v]));
				end
				if (i_y_screen[v] !== i_exp_y[v]) begin
					errors++;
					$display("Error at %0t: vertex %0d y is %0d, expected %0d",
						$time, v, $signed(i_y_screen[v]), $signed(i_exp_y[v]));
				end
			end
			if (i_tri_color !== i_exp_color) begin
				errors++;
				$display("Error at %0t: tri colour is %0d, expected %0d",
					$time, i_tri_color, i_exp_color);
			end
		end
	end

endmodule

//--- tests/vs_tb.sv
// testbench for the vertex stage: runs a table of quads through the DUT and shows each at vblank
module vs_tb import vs_pkg::*; ();

	localparam int NUM_QUADS = 7;
	localparam int BUSY_LIMIT = 1000;		// cycles, well above one quad

	typedef struct packed {
		vec4_t [NUM_VERTS-1:0] world;
		vec4_t row0;
		vec4_t row1;
		vec4_t row3;
		vec4_t normal;
		vec4_t light;
		screen_t [NUM_VERTS-1:0] ex;
		screen_t [NUM_VERTS-1:0] ey;
		shade_t color;
		logic twice;					// second start pulse while busy
	} quad_t;

	logic clk = 1'b0;
	logic reset;
	logic [9:0] x_pos;
	logic [9:0] y_pos;
	logic pc_ready;
	vec4_t world [NUM_VERTS];
	vec4_t normal;
	vec4_t light;
	vec4_t vp_row0;
	vec4_t vp_row1;
	vec4_t vp_row3;
	screen_t x_screen [NUM_VERTS];
	screen_t y_screen [NUM_VERTS];
	shade_t tri_color;
	logic busy;

	logic check_req;
	screen_t [NUM_VERTS-1:0] exp_x;
	screen_t [NUM_VERTS-1:0] exp_y;
	shade_t exp_color;
	int errors;
	int checks;
	int timeouts = 0;
	logic [31:0] seed = 32'hbf21aa85;
	quad_t quads [NUM_QUADS];
	quad_t shown;						// what the raster should see now

	always #2 clk = ~clk;

	vs_top vs_top_inst (
		.clk(clk),
		.reset(reset),
		.i_x(x_pos),
		.i_y(y_pos),
		.i_pc_data_ready(pc_ready),
		.i_world(world),
		.i_normal(normal),
		.i_light(light),
		.i_vp_row0(vp_row0),
		.i_vp_row1(vp_row1),
		.i_vp_row3(vp_row3),
		.o_x_screen(x_screen),
		.o_y_screen(y_screen),
		.o_tri_color(tri_color),
		.o_busy(busy)
	);

	vs_checker check_inst (
		.clk(clk),
		.i_check(check_req),
		.i_exp_x(exp_x),
		.i_exp_y(exp_y),
		.i_exp_color(exp_color),
		.i_x_screen(x_screen),
		.i_y_screen(y_screen),
		.i_tri_color(tri_color),
		.i_busy(busy),
		.o_errors(errors),
		.o_checks(checks)
	);

	bind vs_top vs_assertions assert_inst (
		.clk(clk),
		.reset(reset),
		.i_xform_done(xform_dot.done),
		.i_shade_done(shade_dot.done),
		.i_unit_start(unit_dot.start),
		.i_unit_done(unit_dot.done),
		.i_x(i_x),
		.i_y(i_y),
		.i_tri_color(o_tri_color)
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic vec4_t make_vec(fix16_t x, fix16_t y, fix16_t z, fix16_t w);
		return '{x, y, z, w};
	endfunction

	// Q8.8 products summed in 32 bits, then >>> 8 and cut to 16 bits
	function automatic fix16_t dot_q88(vec4_t a, vec4_t b);
		int acc;
		acc = a.x * b.x + a.y * b.y + a.z * b.z + a.w * b.w;
		return fix16_t'(acc >>> 8);
	endfunction

	function automatic ndc_t divide_q14(fix16_t a, fix16_t b);
		longint num;
		longint den;
		longint q;
		bit neg;
		num = (a < 0) ? -longint'(a) : longint'(a);
		num = num << 14;
		den = (b < 0) ? -longint'(b) : longint'(b);
		neg = (b == 0) ? (a < 0) : ((a < 0) != (b < 0));
		q = (den == 0) ? 64'd65536 : num / den;	// zero divisor saturates
		if (neg && q > 32768)
			q = 32768;
		if (!neg && q > 32767)
			q = 32767;
		return neg ? ndc_t'(-q) : ndc_t'(q);
	endfunction

	function automatic screen_t ndc_to_pixel(ndc_t n, int half);
		int p;
		p = int'(n) * half;
		return screen_t'((p >>> 14) + half);
	endfunction

	function automatic shade_t shade_level(fix16_t d);
		int m;
		m = (d < 0) ? -int'(d) : int'(d);
		m = m / (1 << SHADE_SHIFT);
		return (m > SHADE_MAX) ? shade_t'(SHADE_MAX) : shade_t'(m);
	endfunction

	function automatic quad_t with_expected(quad_t q);
		vec4_t p;
		fix16_t cx;
		fix16_t cy;
		fix16_t cw;
		for (int v = 0; v < NUM_VERTS; v++) begin
			p = make_vec(q.world[v].x, q.world[v].y, q.world[v].z, FIX_ONE);
			cx = dot_q88(p, q.row0);
			cy = dot_q88(p, q.row1);
			cw = dot_q88(p, q.row3);
			q.ex[v] = ndc_to_pixel(divide_q14(cx, cw), SCREEN_HALF_W);
			q.ey[v] = ndc_to_pixel(divide_q14(cy, cw), SCREEN_HALF_H);
		end
		q.color = shade_level(dot_q88(make_vec(q.normal.x, q.normal.y, q.normal.z, 0),
			make_vec(q.light.x, q.light.y, q.light.z, 0)));
		return q;
	endfunction

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// upper lcg bits, signed, spanning +-2^(bits-1)
	function automatic fix16_t rand_fix(int bits);
		logic [31:0] r;
		r = next_rand();
		return fix16_t'($signed(r[31:16]) >>> (16 - bits));
	endfunction

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	task automatic build_quads();
		quad_t q;
		for (int k = 0; k < NUM_QUADS; k++) begin
			q = '0;
			if (k < 3) begin			// identity matrix, x = 320 + 320 * xw
				q.row0 = make_vec(FIX_ONE, 0, 0, 0);
				q.row1 = make_vec(0, FIX_ONE, 0, 0);
				q.row3 = make_vec(0, 0, 0, FIX_ONE);
				for (int v = 0; v < NUM_VERTS; v++) begin
					q.world[v].x = fix16_t'(((v * 3 + k * 5) % 9 - 4) * 64);
					q.world[v].y = fix16_t'(((v * 5 + k * 2 + 1) % 9 - 4) * 64);
					q.world[v].z = fix16_t'(v * 32);
					q.world[v].w = 16'sh1234;	// must be ignored
					q.ex[v] = screen_t'(SCREEN_HALF_W + ((SCREEN_HALF_W * q.world[v].x) >>> 8));
					q.ey[v] = screen_t'(SCREEN_HALF_H + ((SCREEN_HALF_H * q.world[v].y) >>> 8));
				end
				case (k)
					0: begin					// dot 1.0
						q.normal = make_vec(FIX_ONE, 0, 0, 0);
						q.light = make_vec(FIX_ONE, 0, 0, 0);
						q.color = 3'd7;
					end
					1: begin					// dot -0.5, back face
						q.normal = make_vec(-FIX_ONE, 0, 0, 0);
						q.light = make_vec(16'sh0080, 0, 0, 0);
						q.color = 3'd4;
					end
					default: begin				// dot 0.25
						q.normal = make_vec(16'sh0080, 0, 0, 0);
						q.light = make_vec(16'sh0080, 0, 0, 0);
						q.color = 3'd2;
					end
				endcase
			end else begin
				q.row0 = make_vec(rand_fix(10), rand_fix(10), rand_fix(10), rand_fix(10));
				q.row1 = make_vec(rand_fix(10), rand_fix(10), rand_fix(10), rand_fix(10));
				q.row3 = make_vec(rand_fix(7), rand_fix(7), rand_fix(7), 16'sh0200);	// w stays > 0
				for (int v = 0; v < NUM_VERTS; v++)
					q.world[v] = make_vec(rand_fix(10), rand_fix(10), rand_fix(10), rand_fix(16));
				q.normal = make_vec(rand_fix(9), rand_fix(9), rand_fix(9), rand_fix(16));
				q.light = make_vec(rand_fix(9), rand_fix(9), rand_fix(9), rand_fix(16));
				q = with_expected(q);
			end
			q.twice = (k == 1) || (k == 4);
			quads[k] = q;
		end
	endtask

	//////////////////////////////////////////////////
	// driving
	//////////////////////////////////////////////////
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_quad(input quad_t q);
		for (int v = 0; v < NUM_VERTS; v++)
			world[v] = q.world[v];
		vp_row0 = q.row0;
		vp_row1 = q.row1;
		vp_row3 = q.row3;
		normal = q.normal;
		light = q.light;
		pc_ready = 1'b1;
		step();
		pc_ready = 1'b0;
		if (q.twice) begin			// shade done by now, transform still busy
			repeat (30) step();
			// a colour that differs from the first one if this pulse got through
			normal = make_vec(FIX_ONE, 0, 0, 0);
			light = make_vec((q.color == 3'd7) ? 16'sh0000 : FIX_ONE, 0, 0, 0);
			pc_ready = 1'b1;
			step();
			pc_ready = 1'b0;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < BUSY_LIMIT) begin
			step();
			n++;
		end
		if (busy) begin
			$display("timeout: o_busy did not fall within %0d cycles at time %0t",
				BUSY_LIMIT, $time);
			timeouts++;
		end
	endtask

	task automatic expect_outputs(input quad_t q);
		exp_x = q.ex;
		exp_y = q.ey;
		exp_color = q.color;
		check_req = 1'b1;
		step();
		check_req = 1'b0;
	endtask

	task automatic show_frame();
		x_pos = 10'd0;
		y_pos = 10'(VBLANK_LINE);
		step();
		x_pos = 10'd5;				// back into the visible area
		y_pos = 10'd100;
	endtask

	initial begin
		reset = 1'b1;
		x_pos = 10'd5;
		y_pos = 10'd100;
		pc_ready = 1'b0;
		world = '{default: '0};
		normal = '0;
		light = '0;
		vp_row0 = '0;
		vp_row1 = '0;
		vp_row3 = '0;
		check_req = 1'b0;
		exp_x = '0;
		exp_y = '0;
		exp_color = '0;
		shown = '0;
		build_quads();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		expect_outputs(shown);			// cleared by reset
		for (int k = 0; k < NUM_QUADS; k++) begin
			apply_quad(quads[k]);
			wait_idle();
			expect_outputs(shown);		// old frame still on screen
			show_frame();
			shown = quads[k];
			expect_outputs(shown);
		end
		step();
		$display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
			checks, errors, vs_top_inst.assert_inst.fails, timeouts);
		if (errors == 0 && timeouts == 0 && vs_top_inst.assert_inst.fails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- vs_top.f
logic/vs_pkg.sv
logic/dot_if.sv
logic/dot4_unit.sv
logic/dot_arbiter.sv
logic/fixed_divider.sv
logic/vertex_xform.sv
logic/face_shade.sv
logic/frame_latch.sv
logic/vs_top.sv
tests/vs_assertions.sv
tests/vs_checker.sv
tests/vs_tb.sv
